//--- cpu_pkg.sv
package cpu_pkg;

  localparam int data_w          = 16;  // data and register width
  localparam int paddr_w         = 10;  // physical word address
  localparam int page_bits       = 6;   // 64 words per page
  localparam int num_pages       = 16;
  localparam int num_regs        = 16;
  localparam int prog_start      = 0;   // logical address of first instruction
  localparam int first_free_page = 2;   // pages below this are preset at reset

  localparam int pidx_w  = paddr_w - page_bits;  // physical page index
  localparam int lpage_w = data_w - page_bits;   // logical page number

  typedef enum logic [7:0] {
    op_jmp       = 8'd1,
    op_ram2reg   = 8'd2,
    op_reg2ram   = 8'd3,
    op_num2reg   = 8'd4,
    op_reg_plus  = 8'd5,
    op_reg_minus = 8'd6,
    op_exit      = 8'd17
  } opcode_e;

  typedef enum logic [2:0] {
    st_fetch_op,
    st_fetch_val,
    st_decode,
    st_mem_rd,
    st_mem_wr,
    st_halt,
    st_fault
  } ctrl_state_e;

  typedef enum logic [1:0] {
    mmu_idle,
    mmu_walk,
    mmu_alloc,
    mmu_done
  } mmu_state_e;

  // first word is op and reg, second word is val
  typedef struct packed {
    opcode_e           op;
    logic [7:0]        rg;
    logic [data_w-1:0] val;
  } instr_t;

  typedef struct packed {
    logic               cyc;
    logic               stb;
    logic               we;
    logic [paddr_w-1:0] adr;
    logic [data_w-1:0]  dat;
  } wb_req_t;

  typedef struct packed {
    logic [data_w-1:0] dat;
    logic              ack;
  } wb_rsp_t;

endpackage

//--- wb_master_port.sv
`timescale 1ns/1ps

module wb_master_port (
  input  logic                        clka,
  input  logic                        rst,
  input  logic                        bus_req,
  input  logic                        bus_we,
  input  logic [cpu_pkg::paddr_w-1:0] bus_adr,
  input  logic [cpu_pkg::data_w-1:0]  bus_wdat,
  output logic                        bus_done,
  output logic [cpu_pkg::data_w-1:0]  bus_rdat,
  output cpu_pkg::wb_req_t            wb_req,
  input  cpu_pkg::wb_rsp_t            wb_rsp
);
  import cpu_pkg::*;

  wb_req_t req_q;

  assign wb_req = req_q;

  always_ff @(posedge clka) begin
    if (!rst) begin
      req_q.cyc <= 1'b0;
      req_q.stb <= 1'b0;
      req_q.we  <= 1'b0;
      bus_done  <= 1'b0;
    end else begin
      bus_done <= 1'b0;
      if (req_q.cyc && wb_rsp.ack) begin
        req_q.cyc <= 1'b0;  // cycle ends right after ack
        req_q.stb <= 1'b0;
        req_q.we  <= 1'b0;
        bus_rdat  <= wb_rsp.dat;
        bus_done  <= 1'b1;
      end else if (bus_req && !req_q.cyc) begin
        req_q.cyc <= 1'b1;
        req_q.stb <= 1'b1;
        req_q.we  <= bus_we;
        req_q.adr <= bus_adr;  // held until ack
        req_q.dat <= bus_wdat;
      end
    end
  end

endmodule

//--- mmu_pager.sv
`timescale 1ns/1ps

module mmu_pager (
  input  logic                        clka,
  input  logic                        rst,
  input  logic                        xlat_req,
  input  logic [cpu_pkg::data_w-1:0]  xlat_laddr,
  output logic                        xlat_done,
  output logic                        xlat_fault,
  output logic [cpu_pkg::paddr_w-1:0] xlat_paddr
);
  import cpu_pkg::*;

  mmu_state_e           state;
  logic [pidx_w-1:0]    chain_tab [num_pages];  // next page, 0 ends the chain
  logic [lpage_w-1:0]   lpage_tab [num_pages];  // owning logical page, 0 = free
  logic [lpage_w-1:0]   req_lpage;
  logic [page_bits-1:0] req_off;
  logic [pidx_w-1:0]    cur_page;   // walk position, also chain tail on alloc
  logic [pidx_w:0]      scan_ptr;   // one extra bit to run past the last page
  logic [pidx_w:0]      alloc_ptr;
  logic [lpage_w-1:0]   last_lpage;
  logic [pidx_w-1:0]    last_page;
  logic                 last_valid;
  logic [lpage_w-1:0]   in_lpage;

  assign in_lpage = xlat_laddr[data_w-1:page_bits];

  always_ff @(posedge clka) begin
    if (!rst) begin
      state      <= mmu_idle;
      xlat_done  <= 1'b0;
      xlat_fault <= 1'b0;
      alloc_ptr  <= (pidx_w + 1)'(first_free_page);
      last_valid <= 1'b0;
      // preset pages chained 0 -> 1 -> ...; page 0 entry only marks it used
      for (int i = 0; i < num_pages; i++) begin
        if (i < first_free_page) begin
          lpage_tab[i] <= (i == 0) ? lpage_w'(1) : lpage_w'(i);
          chain_tab[i] <= (i + 1 < first_free_page) ? pidx_w'(i + 1) : '0;
        end else begin
          lpage_tab[i] <= '0;
          chain_tab[i] <= '0;
        end
      end
    end else begin
      xlat_done  <= 1'b0;
      xlat_fault <= 1'b0;
      case (state)
        mmu_idle: begin
          if (xlat_req) begin
            req_lpage <= in_lpage;
            req_off   <= xlat_laddr[page_bits-1:0];
            if (in_lpage == '0) begin
              cur_page <= '0;  // logical page 0 lives in page 0
              state    <= mmu_done;
            end else if (last_valid && in_lpage == last_lpage) begin
              cur_page <= last_page;  // one-step hit
              state    <= mmu_done;
            end else begin
              cur_page <= '0;
              state    <= mmu_walk;
            end
          end
        end
        mmu_walk: begin
          if (cur_page != '0 && lpage_tab[cur_page] == req_lpage) begin
            state <= mmu_done;
          end else if (chain_tab[cur_page] == '0) begin
            scan_ptr <= alloc_ptr;
            state    <= mmu_alloc;
          end else begin
            cur_page <= chain_tab[cur_page];
          end
        end
        mmu_alloc: begin
          if (scan_ptr == (pidx_w + 1)'(num_pages)) begin
            xlat_fault <= 1'b1;  // out of pages
            state      <= mmu_idle;
          end else if (lpage_tab[scan_ptr[pidx_w-1:0]] == '0) begin
            lpage_tab[scan_ptr[pidx_w-1:0]] <= req_lpage;
            chain_tab[scan_ptr[pidx_w-1:0]] <= '0;
            chain_tab[cur_page]             <= scan_ptr[pidx_w-1:0];  // append
            cur_page                        <= scan_ptr[pidx_w-1:0];
            alloc_ptr                       <= scan_ptr + 1'b1;
            state                           <= mmu_done;
          end else begin
            scan_ptr <= scan_ptr + 1'b1;
          end
        end
        mmu_done: begin
          xlat_done  <= 1'b1;
          xlat_paddr <= {cur_page, req_off};
          last_lpage <= req_lpage;
          last_page  <= cur_page;
          last_valid <= 1'b1;
          state      <= mmu_idle;
        end
        default: state <= mmu_idle;
      endcase
    end
  end

endmodule

//--- register_alu.sv
`timescale 1ns/1ps

module register_alu (
  input  logic                       clka,
  input  logic                       rst,
  input  logic [3:0]                 reg_num,
  output logic [cpu_pkg::data_w-1:0] reg_rdat,
  input  logic                       reg_we,
  input  cpu_pkg::opcode_e           reg_op,
  input  logic [cpu_pkg::data_w-1:0] reg_wdat
);
  import cpu_pkg::*;

  logic [data_w-1:0] regs [num_regs];

  assign reg_rdat = regs[reg_num];  // combinational read

  always_ff @(posedge clka) begin
    if (!rst) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (reg_we) begin
      case (reg_op)
        op_num2reg:   regs[reg_num] <= reg_wdat;
        op_reg_plus:  regs[reg_num] <= regs[reg_num] + reg_wdat;  // wraps at 16 bits
        op_reg_minus: regs[reg_num] <= regs[reg_num] - reg_wdat;
        default:      regs[reg_num] <= reg_wdat;  // ram2reg load
      endcase
    end
  end

endmodule

//--- cpu_control.sv
`timescale 1ns/1ps

module cpu_control (
  input  logic                        clka,
  input  logic                        rst,
  output logic                        xlat_req,
  output logic [cpu_pkg::data_w-1:0]  xlat_laddr,
  input  logic                        xlat_done,
  input  logic                        xlat_fault,
  input  logic [cpu_pkg::paddr_w-1:0] xlat_paddr,
  output logic                        bus_req,
  output logic                        bus_we,
  output logic [cpu_pkg::paddr_w-1:0] bus_adr,
  output logic [cpu_pkg::data_w-1:0]  bus_wdat,
  input  logic                        bus_done,
  input  logic [cpu_pkg::data_w-1:0]  bus_rdat,
  output logic [3:0]                  reg_num,
  input  logic [cpu_pkg::data_w-1:0]  reg_rdat,
  output logic                        reg_we,
  output cpu_pkg::opcode_e            reg_op,
  output logic [cpu_pkg::data_w-1:0]  reg_wdat,
  output logic                        halted,
  output logic                        fault
);
  import cpu_pkg::*;

  ctrl_state_e       state;
  instr_t            ir;
  logic [data_w-1:0] pc;
  logic              xlat_wait;  // translation in flight
  logic              bus_wait;   // bus transfer in flight
  logic              access;
  logic              data_access;
  logic              reg_class;

  assign data_access = (state == st_mem_rd) || (state == st_mem_wr);
  assign access      = (state == st_fetch_op) || (state == st_fetch_val) || data_access;
  assign reg_class   = (ir.op == op_num2reg) || (ir.op == op_reg_plus) ||
                       (ir.op == op_reg_minus);

  // every access is translate first, then one bus transfer
  assign xlat_req   = access && !xlat_wait && !bus_wait;
  assign xlat_laddr = data_access ? ir.val : pc;
  assign bus_req    = xlat_wait && xlat_done;
  assign bus_we     = (state == st_mem_wr);
  assign bus_adr    = xlat_paddr;
  assign bus_wdat   = reg_rdat;

  assign reg_num  = ir.rg[3:0];
  assign reg_op   = ir.op;
  assign reg_we   = ((state == st_decode) && reg_class) || ((state == st_mem_rd) && bus_done);
  assign reg_wdat = (state == st_mem_rd) ? bus_rdat : ir.val;

  assign halted = (state == st_halt);
  assign fault  = (state == st_fault);

  always_ff @(posedge clka) begin
    if (!rst) begin
      state     <= st_fetch_op;
      pc        <= data_w'(prog_start);
      xlat_wait <= 1'b0;
      bus_wait  <= 1'b0;
    end else begin
      if (xlat_req) begin
        xlat_wait <= 1'b1;
      end
      if (xlat_wait && xlat_fault) begin
        xlat_wait <= 1'b0;
        state     <= st_fault;  // no bus cycle, core stops here
      end
      if (bus_req) begin
        xlat_wait <= 1'b0;
        bus_wait  <= 1'b1;
      end
      if (bus_wait && bus_done) begin
        bus_wait <= 1'b0;
        case (state)
          st_fetch_op: begin
            pc    <= pc + 1'b1;
            state <= st_fetch_val;
          end
          st_fetch_val: begin
            pc    <= pc + 1'b1;
            state <= st_decode;
          end
          default: state <= st_fetch_op;  // data access finished
        endcase
      end
      if (state == st_decode) begin
        case (ir.op)
          op_jmp: begin
            pc    <= ir.val;
            state <= st_fetch_op;
          end
          op_exit:    state <= st_halt;
          op_ram2reg: state <= st_mem_rd;
          op_reg2ram: state <= st_mem_wr;
          default:    state <= st_fetch_op;  // reg ops write this cycle, unknown skipped
        endcase
      end
    end
  end

  // instruction register
  always_ff @(posedge clka) begin
    if (bus_wait && bus_done && state == st_fetch_op) begin
      ir.op <= opcode_e'(bus_rdat[15:8]);
      ir.rg <= bus_rdat[7:0];
    end
    if (bus_wait && bus_done && state == st_fetch_val) begin
      ir.val <= bus_rdat;
    end
  end

endmodule

//--- cpu_top.sv
`timescale 1ns/1ps

module cpu_top (
  input  logic             clka,
  input  logic             rst,
  output cpu_pkg::wb_req_t wb_req,
  input  cpu_pkg::wb_rsp_t wb_rsp,
  output logic             halted,
  output logic             fault
);
  import cpu_pkg::*;

  logic               xlat_req;
  logic [data_w-1:0]  xlat_laddr;
  logic               xlat_done;
  logic               xlat_fault;
  logic [paddr_w-1:0] xlat_paddr;
  logic               bus_req;
  logic               bus_we;
  logic [paddr_w-1:0] bus_adr;
  logic [data_w-1:0]  bus_wdat;
  logic               bus_done;
  logic [data_w-1:0]  bus_rdat;
  logic [3:0]         reg_num;
  logic [data_w-1:0]  reg_rdat;
  logic               reg_we;
  opcode_e            reg_op;
  logic [data_w-1:0]  reg_wdat;

  cpu_control u_control (
    .clka, .rst,
    .xlat_req, .xlat_laddr, .xlat_done, .xlat_fault, .xlat_paddr,
    .bus_req, .bus_we, .bus_adr, .bus_wdat, .bus_done, .bus_rdat,
    .reg_num, .reg_rdat, .reg_we, .reg_op, .reg_wdat,
    .halted, .fault
  );

  register_alu u_regs (
    .clka, .rst, .reg_num, .reg_rdat, .reg_we, .reg_op, .reg_wdat
  );

  mmu_pager u_mmu (
    .clka, .rst, .xlat_req, .xlat_laddr, .xlat_done, .xlat_fault, .xlat_paddr
  );

  wb_master_port u_wb (
    .clka, .rst, .bus_req, .bus_we, .bus_adr, .bus_wdat, .bus_done, .bus_rdat,
    .wb_req, .wb_rsp
  );

endmodule

//--- cpu_checker.sv
`timescale 1ns/1ps

module cpu_checker (
  input logic             clka,
  input logic             rst,
  input cpu_pkg::wb_req_t wb_req,
  input cpu_pkg::wb_rsp_t wb_rsp,
  input logic             halted,
  input logic             fault
);

  int assert_fails = 0;

  stb_has_cyc: assert property (@(posedge clka) disable iff (!rst) wb_req.stb |-> wb_req.cyc)
    else begin
      $error("stb high without cyc");
      assert_fails++;
    end

  // request held until the slave acks
  req_held: assert property (@(posedge clka) disable iff (!rst)
    wb_req.stb && !wb_rsp.ack |=> wb_req.stb && $stable(wb_req.adr) &&
    $stable(wb_req.we) && $stable(wb_req.dat))
    else begin
      $error("request changed while waiting for ack");
      assert_fails++;
    end

  stb_drops: assert property (@(posedge clka) disable iff (!rst)
    wb_req.stb && wb_rsp.ack |=> !wb_req.stb)
    else begin
      $error("stb still high after ack");
      assert_fails++;
    end

  one_end: assert property (@(posedge clka) disable iff (!rst) !(halted && fault))
    else begin
      $error("halted and fault both high");
      assert_fails++;
    end

endmodule

bind cpu_top cpu_checker chk (
  .clka(clka), .rst(rst), .wb_req(wb_req), .wb_rsp(wb_rsp), .halted(halted), .fault(fault)
);

//--- tb_monitor.sv
`timescale 1ns/1ps

module tb_monitor (
  input logic                        clka,
  input cpu_pkg::wb_req_t            wb_req,
  input cpu_pkg::wb_rsp_t            wb_rsp,
  input logic                        halted,
  input logic                        fault,
  input logic                        exp_push,
  input logic [cpu_pkg::paddr_w-1:0] exp_adr,
  input logic [cpu_pkg::data_w-1:0]  exp_dat,
  input logic                        check_end,
  input logic                        exp_fault
);
  import cpu_pkg::*;

  typedef struct packed {
    logic [paddr_w-1:0] adr;
    logic [data_w-1:0]  dat;
  } wr_t;

  wr_t exp_q [$];  // expected writes, oldest first
  int  value_errs     = 0;
  int  missing_writes = 0;
  int  extra_writes   = 0;
  int  outcome_errs   = 0;

  always @(posedge clka) begin
    wr_t want;
    if (exp_push) begin
      exp_q.push_back({exp_adr, exp_dat});
    end
    if (wb_req.cyc && wb_req.stb && wb_req.we && wb_rsp.ack) begin
      if (exp_q.size() == 0) begin
        extra_writes++;
        $display("unexpected write of %h to address %h", wb_req.dat, wb_req.adr);
      end else begin
        want = exp_q.pop_front();
        if (want.adr != wb_req.adr || want.dat != wb_req.dat) begin
          value_errs++;
          $display("error at %0t: wrote %h to %h, expected %h to %h",
                   $time, wb_req.dat, wb_req.adr, want.dat, want.adr);
        end
      end
    end
    if (check_end) begin
      if (exp_q.size() != 0) begin
        $display("%0d expected writes never appeared", exp_q.size());
      end
      missing_writes += exp_q.size();
      exp_q.delete();
      if (exp_fault && !(fault && !halted)) begin
        outcome_errs++;
        $display("the core did not stop with a fault as expected");
      end
      if (!exp_fault && !(halted && !fault)) begin
        outcome_errs++;
        $display("the core did not halt as expected");
      end
    end
  end

endmodule

//--- tb_top.sv
`timescale 1ns/1ps

module tb_top;
  import cpu_pkg::*;

  localparam int mem_words = 1 << paddr_w;
  localparam int run_limit = 20000;  // cycles allowed per test

  logic               clka;
  logic               rst;
  wb_req_t            wb_req;
  wb_rsp_t            wb_rsp = '0;
  logic               halted;
  logic               fault;
  logic               fill_en;
  logic               ld_en;
  logic [paddr_w-1:0] ld_adr;
  logic [data_w-1:0]  ld_dat;
  logic               exp_push;
  logic [paddr_w-1:0] exp_adr;
  logic [data_w-1:0]  exp_dat;
  logic               check_end;
  logic               exp_fault;
  logic [data_w-1:0]  mem [mem_words];
  logic [31:0]        lfsr = 32'h2db9_54e4;
  logic               slave_busy = 1'b0;
  logic [1:0]         wait_left = 2'd0;
  int                 n_tests;
  int                 bad_lines;

  cpu_top dut (.clka, .rst, .wb_req, .wb_rsp, .halted, .fault);

  tb_monitor mon (
    .clka, .wb_req, .wb_rsp, .halted, .fault,
    .exp_push, .exp_adr, .exp_dat, .check_end, .exp_fault
  );

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  initial begin
    clka = 1'b0;
    forever #4 clka = ~clka;
  end

  // wishbone slave memory with 0 to 3 wait states
  always @(posedge clka) begin
    logic [1:0] waits;
    wb_rsp.ack <= 1'b0;
    if (fill_en) begin
      for (int i = 0; i < mem_words; i++) begin
        mem[i] <= 16'hc000 | 16'(i);  // unknown opcodes if ever executed
      end
    end
    if (ld_en) begin
      mem[ld_adr] <= ld_dat;
    end
    if (wb_req.cyc && wb_req.stb && !wb_rsp.ack) begin
      if (slave_busy) begin
        waits = wait_left;
      end else begin
        lfsr     = lfsr_next(lfsr);
        waits[0] = lfsr[0];
        lfsr     = lfsr_next(lfsr);
        waits[1] = lfsr[0];
      end
      if (waits == 2'd0) begin
        wb_rsp.ack <= 1'b1;
        slave_busy <= 1'b0;
        if (wb_req.we) begin
          mem[wb_req.adr] <= wb_req.dat;
        end else begin
          wb_rsp.dat <= mem[wb_req.adr];
        end
      end else begin
        wait_left  <= waits - 2'd1;
        slave_busy <= 1'b1;
      end
    end
  end

  task automatic clear_memory();
    @(posedge clka);
    fill_en <= 1'b1;
    @(posedge clka);
    fill_en <= 1'b0;
  endtask

  task automatic load_word(input logic [paddr_w-1:0] a, input logic [data_w-1:0] d);
    @(posedge clka);
    ld_en  <= 1'b1;
    ld_adr <= a;
    ld_dat <= d;
    @(posedge clka);
    ld_en <= 1'b0;
  endtask

  task automatic push_expected(input logic [paddr_w-1:0] a, input logic [data_w-1:0] d);
    @(posedge clka);
    exp_push <= 1'b1;
    exp_adr  <= a;
    exp_dat  <= d;
    @(posedge clka);
    exp_push <= 1'b0;
  endtask

  task automatic run_test(input logic want_fault);
    int cycles;
    @(posedge clka);
    rst       <= 1'b0;
    exp_fault <= want_fault;
    repeat (16) @(posedge clka);
    rst    <= 1'b1;
    cycles = 0;
    while (!(halted || fault) && cycles < run_limit) begin
      @(posedge clka);
      cycles++;
    end
    if (!(halted || fault)) begin
      $display("timeout: test %0d neither halted nor faulted within %0d cycles",
               n_tests, run_limit);
      $display("Something failed");
      $finish;
    end else begin
      repeat (20) @(posedge clka);  // window for any stray write
      check_end <= 1'b1;
      @(posedge clka);
      check_end <= 1'b0;
      @(posedge clka);  // monitor has counted by now
    end
  endtask

  initial begin
    int                 fd;
    int                 code;
    int                 total;
    string              tok;
    string              kind;
    string              summary;
    logic [8*120-1:0]   skip;
    logic [paddr_w-1:0] a;
    logic [data_w-1:0]  w0;
    logic [data_w-1:0]  w1;
    rst       <= 1'b0;
    fill_en   <= 1'b0;
    ld_en     <= 1'b0;
    ld_adr    <= '0;
    ld_dat    <= '0;
    exp_push  <= 1'b0;
    exp_adr   <= '0;
    exp_dat   <= '0;
    check_end <= 1'b0;
    exp_fault <= 1'b0;
    n_tests   = 0;
    bad_lines = 0;
    fd = $fopen("cpu_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open cpu_tests.txt");
      $display("Something failed");
      $finish;
    end else begin
      while ($fscanf(fd, "%s", tok) == 1) begin
        if (tok.substr(0, 0) == "#") begin
          code = $fgets(skip, fd);  // rest of comment
        end else if (tok == "test") begin
          n_tests++;
          clear_memory();
        end else if (tok == "m") begin
          code = $fscanf(fd, "%h %h %h", a, w0, w1);
          if (code != 3) begin
            bad_lines++;
            $display("malformed memory line in cpu_tests.txt");
          end else begin
            load_word(a, w0);
            load_word(a + 1'b1, w1);
          end
        end else if (tok == "w") begin
          code = $fscanf(fd, "%h %h", a, w0);
          if (code != 2) begin
            bad_lines++;
            $display("malformed write line in cpu_tests.txt");
          end else begin
            push_expected(a, w0);
          end
        end else if (tok == "expect") begin
          code = $fscanf(fd, "%s", kind);
          if (code != 1 || (kind != "halt" && kind != "fault")) begin
            bad_lines++;
            $display("malformed expect line in cpu_tests.txt");
          end else begin
            run_test(kind == "fault");
          end
        end else begin
          bad_lines++;
          $display("unknown keyword %s in cpu_tests.txt", tok);
        end
      end
      $fclose(fd);
      total = mon.value_errs + mon.missing_writes + mon.extra_writes + mon.outcome_errs +
              dut.chk.assert_fails + bad_lines;
      summary = $sformatf("tests %0d, value errors %0d, missing writes %0d",
                          n_tests, mon.value_errs, mon.missing_writes);
      summary = {summary, $sformatf(", extra writes %0d, outcome errors %0d",
                                    mon.extra_writes, mon.outcome_errs)};
      summary = {summary, $sformatf(", assertion failures %0d, bad lines %0d",
                                    dut.chk.assert_fails, bad_lines)};
      $display("%s", summary);
      if (total == 0 && n_tests > 0) begin
        $display("Everything OK");
      end else begin
        $display("Something failed");
      end
      $finish;
    end
  end

endmodule

//--- cpu_tests.txt
# test | m <adr> <word> <word> (loads adr and adr+1) | w <adr> <data> | expect halt|fault
# all numbers hex, adr is physical, w lines are the bus writes in order
# alu wrap, copy, jump over code, unknown opcode, paging of logical pages 3, 9, 3
test
m 000 0401 fff0
m 002 0501 0020
m 004 0601 0011
m 006 0301 0030
m 008 0202 0038
m 00a 0100 0010
m 00c 0302 0032
m 00e 1100 0000
m 010 0900 1234
m 012 0302 0031
m 014 0302 00c5
m 016 0301 0247
m 018 0301 00c1
m 01a 1100 0000
m 038 a5c3 0000
w 030 ffff
w 031 a5c3
w 085 a5c3
w 0c7 ffff
w 081 ffff
expect halt
# pages 2 to 15 used up, logical page 16 faults
test
m 000 0300 0080
m 002 0201 00c0
m 004 0201 0100
m 006 0201 0140
m 008 0201 0180
m 00a 0201 01c0
m 00c 0201 0200
m 00e 0201 0240
m 010 0201 0280
m 012 0201 02c0
m 014 0201 0300
m 016 0201 0340
m 018 0201 0380
m 01a 0201 03c0
m 01c 0300 0400
m 01e 1100 0000
w 080 0000
expect fault

//--- cpu_mmu.f
cpu_pkg.sv
wb_master_port.sv
mmu_pager.sv
register_alu.sv
cpu_control.sv
cpu_top.sv
cpu_checker.sv
tb_monitor.sv
tb_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= cpu_mmu.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= Everything OK

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN) $(SIM_ARGS))"; echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
